// File: read_engine.f
design/read_ctrl_pkg.sv
design/read_stream_fsm.sv
design/read_cmd_gen.sv
design/prefetch_cmd_gen.sv
design/resp_tracker.sv
design/read_engine_ctrl.sv
test/mem_responder.sv
test/read_engine_tb.sv

// File: Bender.yml
package:
  name: read_engine

sources:
  # controller, package first
  - files:
      - design/read_ctrl_pkg.sv
      - design/read_stream_fsm.sv
      - design/read_cmd_gen.sv
      - design/prefetch_cmd_gen.sv
      - design/resp_tracker.sv
      - design/read_engine_ctrl.sv

  # testbench
  - target: test
    files:
      - test/mem_responder.sv
      - test/read_engine_tb.sv

// File: test/read_engine_tb.sv
////////////////////////////////////////////////////////////
// read engine testbench
// runs a table of jobs through the controller against two
// memory models and checks commands, bursts and completion
////////////////////////////////////////////////////////////

module read_engine_tb;

	localparam int ADDR_W         = read_ctrl_pkg::DEFAULT_ADDR_W;
	localparam int COUNT_W        = read_ctrl_pkg::DEFAULT_COUNT_W;
	localparam int CL_BYTES       = read_ctrl_pkg::DEFAULT_CL_BYTES;
	localparam int PAGE_BYTES     = read_ctrl_pkg::DEFAULT_PAGE_BYTES;
	localparam int ELEM_BYTES     = read_ctrl_pkg::DEFAULT_ELEM_BYTES;
	localparam int MAX_BURST      = read_ctrl_pkg::DEFAULT_MAX_BURST;
	localparam int ELEMS_PER_CL   = CL_BYTES / ELEM_BYTES;
	localparam int ELEMS_PER_PAGE = PAGE_BYTES / ELEM_BYTES;
	localparam int NUM_JOBS       = 7;
	localparam int RESET_CYCLES   = 5;
	localparam int CYCLES_PER_CMD = 40;

	logic                    clock;
	logic                    rstn;
	logic                    job_valid;
	logic [ADDR_W-1:0]       job_base;
	logic [COUNT_W-1:0]      job_elems;
	logic                    job_prefetch;
	logic                    cache_mode;
	logic                    rd_buf_alfull;
	logic                    pf_buf_alfull;
	logic                    rd_resp_valid;
	logic [COUNT_W-1:0]      rd_resp_elems;
	logic                    pf_resp_valid;
	logic                    rd_cmd_valid;
	logic [ADDR_W-1:0]       rd_cmd_addr;
	read_ctrl_pkg::read_op_t rd_cmd_op;
	logic [COUNT_W-1:0]      rd_cmd_elems;
	logic                    pf_cmd_valid;
	logic [ADDR_W-1:0]       pf_cmd_addr;
	logic [COUNT_W-1:0]      pf_cmd_elems;
	logic [COUNT_W-1:0]      elems_done;
	logic                    job_done;

	// job table with alfull bit 0 for the read buffer and bit 1 for the touch buffer
	logic [ADDR_W-1:0]  tab_base     [NUM_JOBS];
	logic [COUNT_W-1:0] tab_elems    [NUM_JOBS];
	logic               tab_prefetch [NUM_JOBS];
	logic               tab_cache    [NUM_JOBS];
	logic [1:0]         tab_alfull   [NUM_JOBS];
	logic               table_ready = 1'b0;
	logic [1:0]         alfull_mode;
	logic [31:0]        lfsr_state = 32'h52ff_e417;

	// scoreboard of the running job
	int unsigned        error_count;
	int unsigned        rd_total;
	int unsigned        pf_total;
	int                 job_index;
	logic [ADDR_W-1:0]  exp_base;
	logic [COUNT_W-1:0] exp_elems;
	logic               exp_prefetch;
	logic               exp_cache;
	logic [COUNT_W-1:0] rd_left;
	logic [COUNT_W-1:0] pf_left;
	int                 rd_n;
	int                 pf_n;
	int                 rd_out;
	int                 pf_out;
	logic               prev_rd_alfull;
	logic               prev_pf_alfull;
	logic               prev_done;

	read_engine_ctrl #(
		.ADDR_W     (ADDR_W),
		.COUNT_W    (COUNT_W),
		.CL_BYTES   (CL_BYTES),
		.PAGE_BYTES (PAGE_BYTES),
		.ELEM_BYTES (ELEM_BYTES),
		.MAX_BURST  (MAX_BURST)
	) i_read_engine_ctrl (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_base      (job_base),
		.job_elems     (job_elems),
		.job_prefetch  (job_prefetch),
		.cache_mode    (cache_mode),
		.rd_buf_alfull (rd_buf_alfull),
		.pf_buf_alfull (pf_buf_alfull),
		.rd_resp_valid (rd_resp_valid),
		.rd_resp_elems (rd_resp_elems),
		.pf_resp_valid (pf_resp_valid),
		.rd_cmd_valid  (rd_cmd_valid),
		.rd_cmd_addr   (rd_cmd_addr),
		.rd_cmd_op     (rd_cmd_op),
		.rd_cmd_elems  (rd_cmd_elems),
		.pf_cmd_valid  (pf_cmd_valid),
		.pf_cmd_addr   (pf_cmd_addr),
		.pf_cmd_elems  (pf_cmd_elems),
		.elems_done    (elems_done),
		.job_done      (job_done)
	);

	mem_responder #(.COUNT_W(COUNT_W)) i_rd_responder (
		.clock      (clock),
		.rstn       (rstn),
		.cmd_valid  (rd_cmd_valid),
		.cmd_elems  (rd_cmd_elems),
		.resp_valid (rd_resp_valid),
		.resp_elems (rd_resp_elems)
	);

	mem_responder #(.COUNT_W(COUNT_W)) i_pf_responder (
		.clock      (clock),
		.rstn       (rstn),
		.cmd_valid  (pf_cmd_valid),
		.cmd_elems  (pf_cmd_elems),
		.resp_valid (pf_resp_valid),
		.resp_elems ()
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] bits);
		bits = '0;
		for (int b = 0; b < count; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[6:0], lfsr_state[0]};
		end
	endtask

	task automatic set_row(input int j, input logic [ADDR_W-1:0] base,
	                       input logic [COUNT_W-1:0] elems, input logic prefetch,
	                       input logic cached, input logic [1:0] alfull);
		tab_base[j]     = base;
		tab_elems[j]    = elems;
		tab_prefetch[j] = prefetch;
		tab_cache[j]    = cached;
		tab_alfull[j]   = alfull;
	endtask

	// expected command counts of one job
	function automatic int read_cmds(input int j);
		return (int'(tab_elems[j]) + ELEMS_PER_CL - 1) / ELEMS_PER_CL;
	endfunction

	function automatic int touch_cmds(input int j);
		if (!tab_prefetch[j])
			return 0;
		return (int'(tab_elems[j]) + ELEMS_PER_PAGE - 1) / ELEMS_PER_PAGE;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
	                               input logic [63:0] expected);
		error_count++;
		$display("error %s got %h expected %h in job %0d", name, got, expected, job_index);
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("job %0d: %s", job_index, what);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		rstn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
		// reset state, then idle
		repeat (2) @(posedge clock);
	endtask

	////////////////////////////////////////////////////////////
	// clock, back-pressure and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// random almost-full in about one cycle of four when enabled
	always @(posedge clock) begin
		logic [7:0] bits;
		draw_bits(2, bits);
		rd_buf_alfull <= alfull_mode[0] && (bits[1:0] == 2'b11);
		draw_bits(2, bits);
		pf_buf_alfull <= alfull_mode[1] && (bits[1:0] == 2'b11);
	end

	initial begin
		int unsigned limit;
		wait (table_ready);
		limit = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			limit += RESET_CYCLES + 6 + CYCLES_PER_CMD * (read_cmds(j) + touch_cmds(j));
		repeat (limit) @(posedge clock);
		$display("timeout after %0d cycles in job %0d, %0d errors before it",
		         limit, job_index, error_count);
		$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// command and completion monitor
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		logic [COUNT_W-1:0]      exp_chunk;
		logic [ADDR_W-1:0]       exp_addr;
		read_ctrl_pkg::read_op_t exp_op;
		if (!rstn) begin
			rd_n = 0;
			pf_n = 0;
			rd_out = 0;
			pf_out = 0;
			rd_left = '0;
			pf_left = '0;
			prev_done = 1'b0;
		end else begin
			if (job_valid) begin
				exp_base     = job_base;
				exp_elems    = job_elems;
				exp_prefetch = job_prefetch;
				exp_cache    = cache_mode;
				rd_left      = job_elems;
				pf_left      = job_elems;
			end
			// completion is checked before this edge's responses are counted
			if (job_done && !prev_done) begin
				if (rd_out != 0 || pf_out != 0)
					report_problem("job_done rose with commands still unanswered");
				if (rd_left != '0)
					report_problem("job_done rose before all elements were read");
				if (exp_prefetch && pf_left != '0)
					report_problem("job_done rose before all pages were touched");
				if (elems_done !== exp_elems)
					report_mismatch("elems_done", elems_done, exp_elems);
			end
			prev_done = job_done;
			if (rd_cmd_valid) begin
				rd_total++;
				if (prev_rd_alfull)
					report_problem("read command sent in the cycle after rd_buf_alfull was high");
				if (pf_out != 0)
					report_problem("read command sent while a page touch was unanswered");
				if (exp_prefetch && pf_n == 0)
					report_problem("read command sent before the first page touch");
				if (rd_left == '0) begin
					report_problem("read command sent after all elements were requested");
				end else begin
					exp_addr  = exp_base + ADDR_W'(rd_n) * ADDR_W'(CL_BYTES);
					exp_chunk = (rd_left < ELEMS_PER_CL) ? rd_left : COUNT_W'(ELEMS_PER_CL);
					if (exp_cache)
						exp_op = read_ctrl_pkg::op_read_cl_s;
					else if (rd_left <= ELEMS_PER_CL)
						exp_op = read_ctrl_pkg::op_read_pna;
					else
						exp_op = read_ctrl_pkg::op_read_cl_na;
					if (rd_cmd_addr !== exp_addr)
						report_mismatch("rd_cmd_addr", rd_cmd_addr, exp_addr);
					if (rd_cmd_elems !== exp_chunk)
						report_mismatch("rd_cmd_elems", rd_cmd_elems, exp_chunk);
					if (rd_cmd_op !== exp_op)
						report_mismatch("rd_cmd_op", rd_cmd_op, exp_op);
					rd_left = rd_left - exp_chunk;
				end
				rd_n++;
				rd_out++;
				if (rd_out > MAX_BURST)
					report_problem("more reads unanswered than one burst allows");
			end
			if (pf_cmd_valid) begin
				pf_total++;
				if (!exp_prefetch)
					report_problem("page touch sent for a job without prefetching");
				if (prev_pf_alfull)
					report_problem("page touch sent in the cycle after pf_buf_alfull was high");
				if (rd_out != 0)
					report_problem("page touch sent while reads were unanswered");
				exp_addr  = exp_base - (exp_base % ADDR_W'(PAGE_BYTES)) +
				            ADDR_W'(pf_n) * ADDR_W'(PAGE_BYTES);
				exp_chunk = (pf_left < ELEMS_PER_PAGE) ? pf_left : COUNT_W'(ELEMS_PER_PAGE);
				if (pf_cmd_addr !== exp_addr)
					report_mismatch("pf_cmd_addr", pf_cmd_addr, exp_addr);
				if (pf_cmd_elems !== exp_chunk)
					report_mismatch("pf_cmd_elems", pf_cmd_elems, exp_chunk);
				pf_left = pf_left - exp_chunk;
				pf_n++;
				pf_out++;
			end
			if (rd_resp_valid)
				rd_out--;
			if (pf_resp_valid)
				pf_out--;
		end
		prev_rd_alfull = rd_buf_alfull;
		prev_pf_alfull = pf_buf_alfull;
	end

	////////////////////////////////////////////////////////////
	// job sequence
	////////////////////////////////////////////////////////////

	initial begin
		rstn          = 1'b0;
		job_valid     = 1'b0;
		job_base      = '0;
		job_elems     = '0;
		job_prefetch  = 1'b0;
		cache_mode    = 1'b0;
		rd_buf_alfull = 1'b0;
		pf_buf_alfull = 1'b0;
		alfull_mode   = 2'b00;
		error_count   = 0;
		rd_total      = 0;
		pf_total      = 0;
		job_index     = 0;

		//      job  base                   elems  pf    cache alfull
		set_row(0, 64'h0000_0000_1000_0000, 1,     1'b0, 1'b0, 2'b00);
		set_row(1, 64'h0000_0000_2000_0080, 32,    1'b0, 1'b0, 2'b00);
		set_row(2, 64'h0000_0001_0000_0a40, 300,   1'b1, 1'b0, 2'b00);
		set_row(3, 64'h0000_0002_3456_7f00, 2100,  1'b1, 1'b1, 2'b11);
		set_row(4, 64'h0000_0000_0000_0000, 257,   1'b0, 1'b0, 2'b01);
		set_row(5, 64'h0000_00ff_0000_0004, 1000,  1'b1, 1'b0, 2'b10);
		set_row(6, 64'h0000_0003_0000_1000, 256,   1'b1, 1'b1, 2'b01);
		table_ready = 1'b1;

		for (int j = 0; j < NUM_JOBS; j++) begin
			job_index = j;
			apply_reset();
			if (rd_cmd_valid !== 1'b0 || pf_cmd_valid !== 1'b0 || job_done !== 1'b0)
				report_problem("command valid or job_done not low after reset");
			if (elems_done !== '0)
				report_mismatch("elems_done", elems_done, 0);
			@(posedge clock);
			job_valid    <= 1'b1;
			job_base     <= tab_base[j];
			job_elems    <= tab_elems[j];
			job_prefetch <= tab_prefetch[j];
			cache_mode   <= tab_cache[j];
			alfull_mode  <= tab_alfull[j];
			@(posedge clock);
			job_valid <= 1'b0;
			while (job_done !== 1'b1)
				@(posedge clock);
			@(posedge clock);
		end

		$display("jobs %0d, read commands %0d, page touches %0d, errors %0d",
		         NUM_JOBS, rd_total, pf_total, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: test/mem_responder.sv
////////////////////////////////////////////////////////////
// memory model for one command stream
// answers every command once after a random delay of
// 1 to 7 cycles, one response per cycle, in command order
////////////////////////////////////////////////////////////

module mem_responder #(
	parameter int          COUNT_W = 32,
	parameter logic [31:0] SEED    = 32'h52ff_e417
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               cmd_valid,
	input  logic [COUNT_W-1:0] cmd_elems,
	output logic               resp_valid,
	output logic [COUNT_W-1:0] resp_elems
);

	logic [31:0]        lfsr = SEED;
	int unsigned        cycle;
	int unsigned        last_due;
	int unsigned        due_q [$];
	logic [COUNT_W-1:0] elems_q [$];

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	initial begin
		resp_valid = 1'b0;
		resp_elems = '0;
	end

	always @(posedge clock or negedge rstn) begin
		logic [2:0]  pick;
		int unsigned due;
		if (!rstn) begin
			resp_valid <= 1'b0;
			resp_elems <= '0;
			cycle = 0;
			last_due = 0;
			due_q.delete();
			elems_q.delete();
		end else begin
			cycle = cycle + 1;
			if (cmd_valid) begin
				pick = '0;
				for (int b = 0; b < 3; b++) begin
					lfsr = lfsr_next(lfsr);
					pick = {pick[1:0], lfsr[0]};
				end
				due = cycle + ((pick == 3'd0) ? 7 : pick);
				// keep responses one per cycle
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				elems_q.push_back(cmd_elems);
			end
			resp_valid <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				resp_valid <= 1'b1;
				resp_elems <= elems_q[0];
				void'(due_q.pop_front());
				void'(elems_q.pop_front());
			end
		end
	end

endmodule

// File: design/read_engine_ctrl.sv
////////////////////////////////////////////////////////////
// read stream controller top
// sequencer, read and touch generators and the response
// tracker of one shared-memory read engine
////////////////////////////////////////////////////////////

module read_engine_ctrl #(
	parameter int ADDR_W     = read_ctrl_pkg::DEFAULT_ADDR_W,
	parameter int COUNT_W    = read_ctrl_pkg::DEFAULT_COUNT_W,
	parameter int CL_BYTES   = read_ctrl_pkg::DEFAULT_CL_BYTES,
	parameter int PAGE_BYTES = read_ctrl_pkg::DEFAULT_PAGE_BYTES,
	parameter int ELEM_BYTES = read_ctrl_pkg::DEFAULT_ELEM_BYTES,
	parameter int MAX_BURST  = read_ctrl_pkg::DEFAULT_MAX_BURST
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    job_valid,
	input  logic [ADDR_W-1:0]       job_base,
	input  logic [COUNT_W-1:0]      job_elems,
	input  logic                    job_prefetch,
	input  logic                    cache_mode,
	input  logic                    rd_buf_alfull,
	input  logic                    pf_buf_alfull,
	input  logic                    rd_resp_valid,
	input  logic [COUNT_W-1:0]      rd_resp_elems,
	input  logic                    pf_resp_valid,
	output logic                    rd_cmd_valid,
	output logic [ADDR_W-1:0]       rd_cmd_addr,
	output read_ctrl_pkg::read_op_t rd_cmd_op,
	output logic [COUNT_W-1:0]      rd_cmd_elems,
	output logic                    pf_cmd_valid,
	output logic [ADDR_W-1:0]       pf_cmd_addr,
	output logic [COUNT_W-1:0]      pf_cmd_elems,
	output logic [COUNT_W-1:0]      elems_done,
	output logic                    job_done
);

	// sequencer controls
	logic load;
	logic pf_issue;
	logic rd_issue;
	logic burst_clear;

	// status back to the sequencer
	logic rd_burst_end;
	logic rd_remaining_any;
	logic pf_remaining_any;
	logic rd_drained;
	logic pf_drained;

	read_stream_fsm i_read_stream_fsm (
		.clock            (clock),
		.rstn             (rstn),
		.job_valid        (job_valid),
		.job_prefetch     (job_prefetch),
		.rd_burst_end     (rd_burst_end),
		.rd_remaining_any (rd_remaining_any),
		.pf_remaining_any (pf_remaining_any),
		.rd_drained       (rd_drained),
		.pf_drained       (pf_drained),
		.load             (load),
		.pf_issue         (pf_issue),
		.rd_issue         (rd_issue),
		.burst_clear      (burst_clear),
		.job_done         (job_done)
	);

	read_cmd_gen #(
		.ADDR_W     (ADDR_W),
		.COUNT_W    (COUNT_W),
		.CL_BYTES   (CL_BYTES),
		.ELEM_BYTES (ELEM_BYTES),
		.MAX_BURST  (MAX_BURST)
	) i_read_cmd_gen (
		.clock            (clock),
		.rstn             (rstn),
		.load             (load),
		.job_base         (job_base),
		.job_elems        (job_elems),
		.cache_mode       (cache_mode),
		.rd_issue         (rd_issue),
		.burst_clear      (burst_clear),
		.rd_buf_alfull    (rd_buf_alfull),
		.rd_cmd_valid     (rd_cmd_valid),
		.rd_cmd_addr      (rd_cmd_addr),
		.rd_cmd_op        (rd_cmd_op),
		.rd_cmd_elems     (rd_cmd_elems),
		.rd_burst_end     (rd_burst_end),
		.rd_remaining_any (rd_remaining_any)
	);

	prefetch_cmd_gen #(
		.ADDR_W     (ADDR_W),
		.COUNT_W    (COUNT_W),
		.PAGE_BYTES (PAGE_BYTES),
		.ELEM_BYTES (ELEM_BYTES)
	) i_prefetch_cmd_gen (
		.clock            (clock),
		.rstn             (rstn),
		.load             (load),
		.job_base         (job_base),
		.job_elems        (job_elems),
		.pf_issue         (pf_issue),
		.pf_buf_alfull    (pf_buf_alfull),
		.pf_cmd_valid     (pf_cmd_valid),
		.pf_cmd_addr      (pf_cmd_addr),
		.pf_cmd_elems     (pf_cmd_elems),
		.pf_remaining_any (pf_remaining_any)
	);

	resp_tracker #(
		.COUNT_W   (COUNT_W),
		.MAX_BURST (MAX_BURST)
	) i_resp_tracker (
		.clock         (clock),
		.rstn          (rstn),
		.rd_cmd_valid  (rd_cmd_valid),
		.pf_cmd_valid  (pf_cmd_valid),
		.rd_resp_valid (rd_resp_valid),
		.rd_resp_elems (rd_resp_elems),
		.pf_resp_valid (pf_resp_valid),
		.load          (load),
		.rd_drained    (rd_drained),
		.pf_drained    (pf_drained),
		.elems_done    (elems_done)
	);

endmodule

// File: design/resp_tracker.sv
////////////////////////////////////////////////////////////
// response tracker
// outstanding commands per stream and the running total
// of elements returned by read responses
////////////////////////////////////////////////////////////

module resp_tracker #(
	parameter int COUNT_W   = read_ctrl_pkg::DEFAULT_COUNT_W,
	parameter int MAX_BURST = read_ctrl_pkg::DEFAULT_MAX_BURST
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               rd_cmd_valid,
	input  logic               pf_cmd_valid,
	input  logic               rd_resp_valid,
	input  logic [COUNT_W-1:0] rd_resp_elems,
	input  logic               pf_resp_valid,
	input  logic               load,
	output logic               rd_drained,
	output logic               pf_drained,
	output logic [COUNT_W-1:0] elems_done
);

	localparam int OUT_W = $clog2(MAX_BURST + 1);

	// index 0 is the read stream, 1 the touch stream
	logic [1:0]       cmd_seen;
	logic [1:0]       resp_seen;
	logic [OUT_W-1:0] outstanding [2];

	assign cmd_seen  = {pf_cmd_valid, rd_cmd_valid};
	assign resp_seen = {pf_resp_valid, rd_resp_valid};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding[0] <= '0;
			outstanding[1] <= '0;
		end else begin
			for (int s = 0; s < 2; s++) begin
				outstanding[s] <= outstanding[s] + OUT_W'(cmd_seen[s]) - OUT_W'(resp_seen[s]);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			elems_done <= '0;
		end else if (load) begin
			elems_done <= '0;
		end else if (rd_resp_valid) begin
			elems_done <= elems_done + rd_resp_elems;
		end
	end

	assign rd_drained = (outstanding[0] == '0);
	assign pf_drained = (outstanding[1] == '0);

endmodule

// File: design/prefetch_cmd_gen.sv
////////////////////////////////////////////////////////////
// page touch command generator
// one touch per request, walking page by page from the
// page-aligned job base
////////////////////////////////////////////////////////////

module prefetch_cmd_gen #(
	parameter int ADDR_W     = read_ctrl_pkg::DEFAULT_ADDR_W,
	parameter int COUNT_W    = read_ctrl_pkg::DEFAULT_COUNT_W,
	parameter int PAGE_BYTES = read_ctrl_pkg::DEFAULT_PAGE_BYTES,
	parameter int ELEM_BYTES = read_ctrl_pkg::DEFAULT_ELEM_BYTES
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               load,
	input  logic [ADDR_W-1:0]  job_base,
	input  logic [COUNT_W-1:0] job_elems,
	input  logic               pf_issue,
	input  logic               pf_buf_alfull,
	output logic               pf_cmd_valid,
	output logic [ADDR_W-1:0]  pf_cmd_addr,
	output logic [COUNT_W-1:0] pf_cmd_elems,
	output logic               pf_remaining_any
);

	localparam int ELEMS_PER_PAGE = PAGE_BYTES / ELEM_BYTES;

	logic [ADDR_W-1:0]  page_base;
	logic [ADDR_W-1:0]  page_offset;
	logic [COUNT_W-1:0] remaining;
	logic [COUNT_W-1:0] chunk;
	logic               req_held;
	logic               issue_ok;

	assign chunk    = (remaining <= COUNT_W'(ELEMS_PER_PAGE)) ?
	                  remaining : COUNT_W'(ELEMS_PER_PAGE);
	assign issue_ok = (pf_issue || req_held) && !pf_buf_alfull && (remaining != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pf_cmd_valid <= 1'b0;
			req_held     <= 1'b0;
			remaining    <= '0;
			page_offset  <= '0;
		end else begin
			pf_cmd_valid <= issue_ok;
			// keep the request alive while the buffer is almost full
			req_held     <= (pf_issue || req_held) && !issue_ok && (remaining != '0);
			if (load) begin
				remaining   <= job_elems;
				page_offset <= '0;
				req_held    <= 1'b0;
			end else if (issue_ok) begin
				remaining   <= remaining - chunk;
				page_offset <= page_offset + ADDR_W'(PAGE_BYTES);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			page_base <= job_base & ~ADDR_W'(PAGE_BYTES - 1);
		if (issue_ok) begin
			pf_cmd_addr  <= page_base + page_offset;
			pf_cmd_elems <= chunk;
		end
	end

	assign pf_remaining_any = (remaining != '0);

endmodule

// File: design/read_cmd_gen.sv
////////////////////////////////////////////////////////////
// cache-line read command generator
// cuts the remaining job into line reads, picks the opcode
// and counts commands in the current burst
////////////////////////////////////////////////////////////

module read_cmd_gen #(
	parameter int ADDR_W     = read_ctrl_pkg::DEFAULT_ADDR_W,
	parameter int COUNT_W    = read_ctrl_pkg::DEFAULT_COUNT_W,
	parameter int CL_BYTES   = read_ctrl_pkg::DEFAULT_CL_BYTES,
	parameter int ELEM_BYTES = read_ctrl_pkg::DEFAULT_ELEM_BYTES,
	parameter int MAX_BURST  = read_ctrl_pkg::DEFAULT_MAX_BURST
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    load,
	input  logic [ADDR_W-1:0]       job_base,
	input  logic [COUNT_W-1:0]      job_elems,
	input  logic                    cache_mode,
	input  logic                    rd_issue,
	input  logic                    burst_clear,
	input  logic                    rd_buf_alfull,
	output logic                    rd_cmd_valid,
	output logic [ADDR_W-1:0]       rd_cmd_addr,
	output read_ctrl_pkg::read_op_t rd_cmd_op,
	output logic [COUNT_W-1:0]      rd_cmd_elems,
	output logic                    rd_burst_end,
	output logic                    rd_remaining_any
);

	localparam int ELEMS_PER_CL = CL_BYTES / ELEM_BYTES;
	localparam int BURST_W      = $clog2(MAX_BURST + 1);

	logic [ADDR_W-1:0]       base_q;
	logic [ADDR_W-1:0]       offset;
	logic [COUNT_W-1:0]      remaining;
	logic [BURST_W-1:0]      burst_cnt;
	logic                    last_chunk;
	logic [COUNT_W-1:0]      chunk;
	logic                    issue_ok;
	read_ctrl_pkg::read_op_t next_op;

	assign last_chunk = (remaining <= COUNT_W'(ELEMS_PER_CL));
	assign chunk      = last_chunk ? remaining : COUNT_W'(ELEMS_PER_CL);
	assign issue_ok   = rd_issue && !rd_buf_alfull && (remaining != '0) &&
	                    (burst_cnt < BURST_W'(MAX_BURST));

	// shared read when cached, otherwise non-allocating with a partial tail
	always_comb begin
		if (cache_mode)
			next_op = read_ctrl_pkg::op_read_cl_s;
		else if (last_chunk)
			next_op = read_ctrl_pkg::op_read_pna;
		else
			next_op = read_ctrl_pkg::op_read_cl_na;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_cmd_valid <= 1'b0;
			remaining    <= '0;
			offset       <= '0;
			burst_cnt    <= '0;
		end else begin
			rd_cmd_valid <= issue_ok;
			if (load) begin
				remaining <= job_elems;
				offset    <= '0;
				burst_cnt <= '0;
			end else if (issue_ok) begin
				remaining <= remaining - chunk;
				offset    <= offset + ADDR_W'(CL_BYTES);
				burst_cnt <= burst_cnt + 1'b1;
			end else if (burst_clear) begin
				burst_cnt <= '0;
			end
		end
	end

	// command fields
	always_ff @(posedge clock) begin
		if (load)
			base_q <= job_base;
		if (issue_ok) begin
			rd_cmd_addr  <= base_q + offset;
			rd_cmd_op    <= next_op;
			rd_cmd_elems <= chunk;
		end
	end

	assign rd_burst_end     = (burst_cnt == BURST_W'(MAX_BURST)) || (remaining == '0);
	assign rd_remaining_any = (remaining != '0);

endmodule

// File: design/read_stream_fsm.sv
////////////////////////////////////////////////////////////
// read stream sequencer
// walks a job through setup, optional page touch, bursts
// of cache-line reads and the drain of each burst
////////////////////////////////////////////////////////////

module read_stream_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic job_valid,
	input  logic job_prefetch,
	input  logic rd_burst_end,
	input  logic rd_remaining_any,
	input  logic pf_remaining_any,
	input  logic rd_drained,
	input  logic pf_drained,
	output logic load,
	output logic pf_issue,
	output logic rd_issue,
	output logic burst_clear,
	output logic job_done
);

	read_ctrl_pkg::stream_state_t state;
	read_ctrl_pkg::stream_state_t next_state;
	logic                         prefetch_q;

	////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= read_ctrl_pkg::st_reset;
		end else begin
			state <= next_state;
		end
	end

	// prefetch flag of the running job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prefetch_q <= 1'b0;
		end else if (load) begin
			prefetch_q <= job_prefetch;
		end
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			read_ctrl_pkg::st_reset: begin
				next_state = read_ctrl_pkg::st_idle;
			end
			read_ctrl_pkg::st_idle: begin
				if (job_valid)
					next_state = read_ctrl_pkg::st_setup;
			end
			read_ctrl_pkg::st_setup: begin
				// flag is captured on this same edge, so look at the input
				if (job_prefetch)
					next_state = read_ctrl_pkg::st_pf_start;
				else
					next_state = read_ctrl_pkg::st_rd_start;
			end
			read_ctrl_pkg::st_pf_start: begin
				next_state = read_ctrl_pkg::st_pf_req;
			end
			read_ctrl_pkg::st_pf_req: begin
				// touch is out once the tracker sees it or nothing is left
				if (!pf_drained || !pf_remaining_any)
					next_state = read_ctrl_pkg::st_pf_pending;
			end
			read_ctrl_pkg::st_pf_pending: begin
				if (pf_drained)
					next_state = read_ctrl_pkg::st_rd_start;
			end
			read_ctrl_pkg::st_rd_start: begin
				next_state = read_ctrl_pkg::st_rd_req;
			end
			read_ctrl_pkg::st_rd_req: begin
				if (rd_burst_end)
					next_state = read_ctrl_pkg::st_rd_pending;
			end
			read_ctrl_pkg::st_rd_pending: begin
				if (rd_drained)
					next_state = read_ctrl_pkg::st_rd_done;
			end
			read_ctrl_pkg::st_rd_done: begin
				if (pf_remaining_any && prefetch_q)
					next_state = read_ctrl_pkg::st_pf_start;
				else if (rd_remaining_any)
					next_state = read_ctrl_pkg::st_rd_start;
				else
					next_state = read_ctrl_pkg::st_final;
			end
			read_ctrl_pkg::st_final: begin
				next_state = read_ctrl_pkg::st_final;
			end
			default: begin
				next_state = read_ctrl_pkg::st_reset;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// state decoded controls
	////////////////////////////////////////////////////////////

	assign load        = (state == read_ctrl_pkg::st_setup);
	assign pf_issue    = (state == read_ctrl_pkg::st_pf_start) && prefetch_q;
	assign rd_issue    = (state == read_ctrl_pkg::st_rd_req);
	assign burst_clear = (state == read_ctrl_pkg::st_pf_start) ||
	                     (state == read_ctrl_pkg::st_rd_start);
	// held until reset
	assign job_done    = (state == read_ctrl_pkg::st_final);

endmodule

// File: design/read_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// read stream controller shared definitions
// sequencing states, read opcodes and the default geometry
// of the shared-memory read path
////////////////////////////////////////////////////////////

package read_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// job sequencing states
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		st_reset      = 4'd0,
		st_idle       = 4'd1,
		st_setup      = 4'd2,
		st_pf_start   = 4'd3,
		st_pf_req     = 4'd4,
		st_pf_pending = 4'd5,
		st_rd_start   = 4'd6,
		st_rd_req     = 4'd7,
		st_rd_pending = 4'd8,
		st_rd_done    = 4'd9,
		st_final      = 4'd10
	} stream_state_t;

	////////////////////////////////////////////////////////////
	// read opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_read_cl_s  = 2'd0,
		op_read_cl_na = 2'd1,
		op_read_pna   = 2'd2
	} read_op_t;

	////////////////////////////////////////////////////////////
	// default geometry
	////////////////////////////////////////////////////////////

	localparam int DEFAULT_ADDR_W     = 64;
	localparam int DEFAULT_COUNT_W    = 32;
	localparam int DEFAULT_CL_BYTES   = 128;
	localparam int DEFAULT_PAGE_BYTES = 4096;
	localparam int DEFAULT_ELEM_BYTES = 4;
	// commands per burst before the stream must drain
	localparam int DEFAULT_MAX_BURST  = 8;

endpackage
